//--- gat_pkg.sv
`default_nettype none

package gat_pkg;

  localparam int NUM_FEAT_IN   = 8;
  localparam int NUM_FEAT_OUT  = 4;
  localparam int MAX_NODES     = 4;
  localparam int DATA_W        = 8;
  localparam int WH_W          = 12;
  localparam int COEF_W        = 8;
  localparam int FEAT_W        = 16;
  localparam int ACC_W         = 32;
  localparam int WH_SHIFT      = 4;
  localparam int SCORE_SHIFT   = 8;
  localparam int AGGR_SHIFT    = 8;
  localparam int MEM_DEPTH     = 16;
  localparam int MEM_ADDR_W    = 4;
  localparam int COEF_ROW_ADDR = 4;
  localparam int NODE_CNT_W    = 3;
  localparam int NUM_CLIENTS   = 3;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef data_t [NUM_FEAT_IN-1:0] h_row_t;
  typedef data_t [NUM_FEAT_OUT-1:0][NUM_FEAT_IN-1:0] wgt_t;
  // Lower half a_self, upper half a_neigh
  typedef data_t [2*NUM_FEAT_OUT-1:0] att_vec_t;

  typedef logic signed [WH_W-1:0] wh_elem_t;
  typedef wh_elem_t [NUM_FEAT_OUT-1:0] wh_row_t;
  typedef logic [COEF_W-1:0] coef_t;
  // Two spare slots on top, node coefficients in slots 0 to 3
  typedef coef_t [MAX_NODES+1:0] coef_row_t;

  // Node rows and the coefficient row share one memory word
  typedef union packed {
    wh_row_t   wh;
    coef_row_t coef;
  } mem_word_u;

  typedef logic signed [FEAT_W-1:0] feat_t;
  typedef feat_t [NUM_FEAT_OUT-1:0] feat_vec_t;
  typedef logic [NODE_CNT_W-1:0] node_cnt_t;

  function automatic wh_elem_t sat_wh(input logic signed [ACC_W-1:0] acc);
    logic signed [ACC_W-1:0] s;
    s = acc >>> WH_SHIFT;
    if (s > 2**(WH_W-1) - 1) begin
      return wh_elem_t'(2**(WH_W-1) - 1);
    end else if (s < -(2**(WH_W-1))) begin
      return wh_elem_t'(-(2**(WH_W-1)));
    end
    return wh_elem_t'(s);
  endfunction

  function automatic coef_t clamp_coef(input logic signed [ACC_W-1:0] acc);
    logic signed [ACC_W-1:0] s;
    s = acc >>> SCORE_SHIFT;
    if (s < 0) begin
      return '0;
    end else if (s > 2**COEF_W - 1) begin
      return '1;
    end
    return coef_t'(s);
  endfunction

  function automatic feat_t sat_feat(input logic signed [ACC_W-1:0] acc);
    logic signed [ACC_W-1:0] s;
    s = acc >>> AGGR_SHIFT;
    if (s > 2**(FEAT_W-1) - 1) begin
      return feat_t'(2**(FEAT_W-1) - 1);
    end else if (s < -(2**(FEAT_W-1))) begin
      return feat_t'(-(2**(FEAT_W-1)));
    end
    return feat_t'(s);
  endfunction

endpackage

`default_nettype wire

//--- mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if import gat_pkg::*; ();

  logic                  req;
  logic                  we;
  logic [MEM_ADDR_W-1:0] addr;
  mem_word_u             wdata;
  logic                  gnt;
  logic                  rvalid;
  mem_word_u             rdata;

  // Request held by the stage until gnt, read data one cycle after gnt
  modport client (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport mem (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

//--- shared_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module shared_mem_arbiter import gat_pkg::*; (
  input  wire clk,
  input  wire rst_n,
  mem_if.mem  proj_port,
  mem_if.mem  score_port,
  mem_if.mem  aggr_port
);

  logic [NUM_CLIENTS-1:0]         req;
  logic [NUM_CLIENTS-1:0]         we_vec;
  logic [NUM_CLIENTS-1:0]         gnt;
  logic [MEM_ADDR_W-1:0]          addr_arr [NUM_CLIENTS];
  mem_word_u                      wdata_arr [NUM_CLIENTS];
  logic [$clog2(NUM_CLIENTS)-1:0] last_q;
  logic [$clog2(NUM_CLIENTS)-1:0] gnt_idx;
  logic                           gnt_any;
  logic [NUM_CLIENTS-1:0]         rvalid_q;
  mem_word_u                      rdata_q;
  mem_word_u                      mem_q [MEM_DEPTH];

  assign req          = {aggr_port.req, score_port.req, proj_port.req};
  assign we_vec       = {aggr_port.we, score_port.we, proj_port.we};
  assign addr_arr[0]  = proj_port.addr;
  assign addr_arr[1]  = score_port.addr;
  assign addr_arr[2]  = aggr_port.addr;
  assign wdata_arr[0] = proj_port.wdata;
  assign wdata_arr[1] = score_port.wdata;
  assign wdata_arr[2] = aggr_port.wdata;

  // Round robin, search starts after the last granted client
  always_comb begin
    int idx;
    gnt_any = 1'b0;
    gnt_idx = '0;
    for (int k = 1; k <= NUM_CLIENTS; k++) begin
      idx = (int'(last_q) + k) % NUM_CLIENTS;
      if (!gnt_any && req[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = idx[$clog2(NUM_CLIENTS)-1:0];
      end
    end
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      gnt[c] = gnt_any && (int'(gnt_idx) == c);
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_any && we_vec[gnt_idx]) begin
      mem_q[addr_arr[gnt_idx]] <= wdata_arr[gnt_idx];
    end
    if (gnt_any && !we_vec[gnt_idx]) begin
      rdata_q <= mem_q[addr_arr[gnt_idx]];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= '0;
      last_q   <= $clog2(NUM_CLIENTS)'(NUM_CLIENTS - 1);
    end else begin
      rvalid_q <= gnt & ~we_vec;
      if (gnt_any) begin
        last_q <= gnt_idx;
      end
    end
  end

  assign proj_port.gnt     = gnt[0];
  assign score_port.gnt    = gnt[1];
  assign aggr_port.gnt     = gnt[2];
  assign proj_port.rvalid  = rvalid_q[0];
  assign score_port.rvalid = rvalid_q[1];
  assign aggr_port.rvalid  = rvalid_q[2];
  assign proj_port.rdata   = rdata_q;
  assign score_port.rdata  = rdata_q;
  assign aggr_port.rdata   = rdata_q;

endmodule

`default_nettype wire

//--- wh_projection.sv
`timescale 1ns/1ps
`default_nettype none

module wh_projection import gat_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       h_valid_i,
  input  h_row_t    h_row_i,
  input  wire       h_last_i,
  output logic      h_ready_o,
  input  wgt_t      wgt_i,
  mem_if.client     mem,
  output logic      sg_valid_o,
  output node_cnt_t sg_nodes_o,
  input  wire       sg_ready_i,
  input  wire       bank_free_i
);

  logic                           mac_q;
  logic                           wr_q;
  logic                           hand_q;
  logic                           last_q;
  logic                           bank_q;
  logic [1:0]                     banks_q;
  node_cnt_t                      node_idx_q;
  logic [$clog2(NUM_FEAT_IN)-1:0] feat_q;
  logic                           accept;
  logic                           first_row;
  h_row_t                         h_q;
  logic signed [ACC_W-1:0]        acc_q [NUM_FEAT_OUT];
  mem_word_u                      wr_word;

  // A new subgraph needs a free bank, later rows do not
  assign first_row = (node_idx_q == '0);
  assign h_ready_o = !mac_q && !wr_q && !hand_q && (!first_row || banks_q < 2'd2);
  assign accept    = h_valid_i && h_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mac_q      <= 1'b0;
      wr_q       <= 1'b0;
      hand_q     <= 1'b0;
      last_q     <= 1'b0;
      bank_q     <= 1'b0;
      banks_q    <= '0;
      node_idx_q <= '0;
      feat_q     <= '0;
    end else begin
      banks_q <= banks_q + 2'(accept && first_row) - 2'(bank_free_i);
      if (accept) begin
        mac_q  <= 1'b1;
        feat_q <= '0;
        last_q <= h_last_i || (node_idx_q == NODE_CNT_W'(MAX_NODES - 1));
      end
      if (mac_q) begin
        feat_q <= feat_q + 1'b1;
        if (feat_q == $clog2(NUM_FEAT_IN)'(NUM_FEAT_IN - 1)) begin
          mac_q <= 1'b0;
          wr_q  <= 1'b1;
        end
      end
      if (wr_q && mem.gnt) begin
        wr_q <= 1'b0;
        if (last_q) begin
          hand_q <= 1'b1;
        end else begin
          node_idx_q <= node_idx_q + 1'b1;
        end
      end
      if (hand_q && sg_ready_i) begin
        hand_q     <= 1'b0;
        bank_q     <= ~bank_q;
        node_idx_q <= '0;
      end
    end
  end

  // Four MACs, one input feature per cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      h_q <= h_row_i;
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        acc_q[o] <= '0;
      end
    end else if (mac_q) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        acc_q[o] <= acc_q[o] + h_q[feat_q] * wgt_i[o][feat_q];
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      wr_word.wh[o] = sat_wh(acc_q[o]);
    end
  end

  assign mem.req    = wr_q;
  assign mem.we     = 1'b1;
  assign mem.addr   = {bank_q, node_idx_q};
  assign mem.wdata  = wr_word;
  assign sg_valid_o = hand_q;
  assign sg_nodes_o = node_idx_q + 1'b1;

endmodule

`default_nettype wire

//--- attention_scorer.sv
`timescale 1ns/1ps
`default_nettype none

module attention_scorer import gat_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  input  att_vec_t  att_i,
  mem_if.client     mem,
  input  wire       sg_valid_i,
  input  node_cnt_t sg_nodes_i,
  output logic      sg_ready_o,
  output logic      sg_valid_o,
  output node_cnt_t sg_nodes_o,
  input  wire       sg_ready_i
);

  logic                    rd_q;
  logic                    wait_q;
  logic                    wr_q;
  logic                    hand_q;
  logic                    bank_q;
  node_cnt_t               nodes_q;
  node_cnt_t               j_q;
  logic                    accept;
  logic signed [ACC_W-1:0] self_q;
  logic signed [ACC_W-1:0] self_dot;
  logic signed [ACC_W-1:0] neigh_dot;
  logic signed [ACC_W-1:0] self_now;
  coef_row_t               coef_q;
  mem_word_u               wr_word;

  assign sg_ready_o = !rd_q && !wait_q && !wr_q && !hand_q;
  assign accept     = sg_valid_i && sg_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q    <= 1'b0;
      wait_q  <= 1'b0;
      wr_q    <= 1'b0;
      hand_q  <= 1'b0;
      bank_q  <= 1'b0;
      nodes_q <= '0;
      j_q     <= '0;
    end else begin
      if (accept) begin
        nodes_q <= sg_nodes_i;
        j_q     <= '0;
        rd_q    <= 1'b1;
      end
      if (rd_q && mem.gnt) begin
        rd_q   <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && mem.rvalid) begin
        wait_q <= 1'b0;
        if (j_q == nodes_q - 1'b1) begin
          wr_q <= 1'b1;
        end else begin
          j_q  <= j_q + 1'b1;
          rd_q <= 1'b1;
        end
      end
      if (wr_q && mem.gnt) begin
        wr_q   <= 1'b0;
        hand_q <= 1'b1;
      end
      if (hand_q && sg_ready_i) begin
        hand_q <= 1'b0;
        bank_q <= ~bank_q;
      end
    end
  end

  always_comb begin
    self_dot  = '0;
    neigh_dot = '0;
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      self_dot  = self_dot + att_i[o] * mem.rdata.wh[o];
      neigh_dot = neigh_dot + att_i[NUM_FEAT_OUT + o] * mem.rdata.wh[o];
    end
  end

  // Node 0 supplies the self term and its own neighbour term in one read
  assign self_now = (j_q == '0) ? self_dot : self_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      coef_q <= '0;
    end else if (wait_q && mem.rvalid) begin
      coef_q[j_q] <= clamp_coef(self_now + neigh_dot);
      self_q      <= self_now;
    end
  end

  always_comb begin
    wr_word.coef = coef_q;
  end

  assign mem.req    = rd_q || wr_q;
  assign mem.we     = wr_q;
  assign mem.addr   = wr_q ? {bank_q, NODE_CNT_W'(COEF_ROW_ADDR)} : {bank_q, j_q};
  assign mem.wdata  = wr_word;
  assign sg_valid_o = hand_q;
  assign sg_nodes_o = nodes_q;

endmodule

`default_nettype wire

//--- neighbor_aggregator.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_aggregator import gat_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  mem_if.client     mem,
  input  wire       sg_valid_i,
  input  node_cnt_t sg_nodes_i,
  output logic      sg_ready_o,
  output logic      feat_valid_o,
  output feat_vec_t feat_o,
  input  wire       feat_ready_i,
  output logic      bank_free_o
);

  logic                    req_q;
  logic                    wait_q;
  logic                    have_coef_q;
  logic                    feat_valid_q;
  logic                    bank_q;
  node_cnt_t               nodes_q;
  node_cnt_t               j_q;
  logic                    accept;
  logic                    last_node;
  coef_row_t               coef_q;
  logic signed [ACC_W-1:0] acc_q [NUM_FEAT_OUT];

  assign sg_ready_o = !req_q && !wait_q && !feat_valid_q;
  assign accept     = sg_valid_i && sg_ready_o;
  assign last_node  = (j_q == nodes_q - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q        <= 1'b0;
      wait_q       <= 1'b0;
      have_coef_q  <= 1'b0;
      feat_valid_q <= 1'b0;
      bank_q       <= 1'b0;
      nodes_q      <= '0;
      j_q          <= '0;
    end else begin
      if (accept) begin
        nodes_q     <= sg_nodes_i;
        j_q         <= '0;
        have_coef_q <= 1'b0;
        req_q       <= 1'b1;
      end
      if (req_q && mem.gnt) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && mem.rvalid) begin
        wait_q <= 1'b0;
        if (!have_coef_q) begin
          have_coef_q <= 1'b1;
          req_q       <= 1'b1;
        end else if (last_node) begin
          feat_valid_q <= 1'b1;
        end else begin
          j_q   <= j_q + 1'b1;
          req_q <= 1'b1;
        end
      end
      if (feat_valid_q && feat_ready_i) begin
        feat_valid_q <= 1'b0;
        bank_q       <= ~bank_q;
      end
    end
  end

  // First read brings the coefficient row, then one Wh row per node
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        acc_q[o] <= '0;
      end
    end else if (wait_q && mem.rvalid) begin
      if (!have_coef_q) begin
        coef_q <= mem.rdata.coef;
      end else begin
        for (int o = 0; o < NUM_FEAT_OUT; o++) begin
          acc_q[o] <= acc_q[o] + $signed({1'b0, coef_q[j_q]}) * mem.rdata.wh[o];
        end
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      feat_o[o] = sat_feat(acc_q[o]);
    end
  end

  assign mem.req      = req_q;
  assign mem.we       = 1'b0;
  assign mem.addr     = have_coef_q ? {bank_q, j_q} : {bank_q, NODE_CNT_W'(COEF_ROW_ADDR)};
  assign mem.wdata    = '0;
  assign feat_valid_o = feat_valid_q;
  assign bank_free_o  = feat_valid_q && feat_ready_i;

endmodule

`default_nettype wire

//--- gat_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

module gat_layer_top import gat_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       h_valid_i,
  output logic      h_ready_o,
  input  h_row_t    h_row_i,
  input  wire       h_last_i,
  input  wgt_t      wgt_i,
  input  att_vec_t  att_i,
  output logic      feat_valid_o,
  input  wire       feat_ready_i,
  output feat_vec_t feat_o
);

  logic      p2s_valid;
  logic      p2s_ready;
  node_cnt_t p2s_nodes;
  logic      s2a_valid;
  logic      s2a_ready;
  node_cnt_t s2a_nodes;
  logic      bank_free;

  mem_if proj_mem ();
  mem_if score_mem ();
  mem_if aggr_mem ();

  shared_mem_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .proj_port  (proj_mem),
    .score_port (score_mem),
    .aggr_port  (aggr_mem)
  );

  wh_projection u_projection (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_valid_i   (h_valid_i),
    .h_row_i     (h_row_i),
    .h_last_i    (h_last_i),
    .h_ready_o   (h_ready_o),
    .wgt_i       (wgt_i),
    .mem         (proj_mem),
    .sg_valid_o  (p2s_valid),
    .sg_nodes_o  (p2s_nodes),
    .sg_ready_i  (p2s_ready),
    .bank_free_i (bank_free)
  );

  attention_scorer u_scorer (
    .clk        (clk),
    .rst_n      (rst_n),
    .att_i      (att_i),
    .mem        (score_mem),
    .sg_valid_i (p2s_valid),
    .sg_nodes_i (p2s_nodes),
    .sg_ready_o (p2s_ready),
    .sg_valid_o (s2a_valid),
    .sg_nodes_o (s2a_nodes),
    .sg_ready_i (s2a_ready)
  );

  neighbor_aggregator u_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem          (aggr_mem),
    .sg_valid_i   (s2a_valid),
    .sg_nodes_i   (s2a_nodes),
    .sg_ready_o   (s2a_ready),
    .feat_valid_o (feat_valid_o),
    .feat_o       (feat_o),
    .feat_ready_i (feat_ready_i),
    .bank_free_o  (bank_free)
  );

endmodule

`default_nettype wire

//--- tb_gat_layer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gat_layer import gat_pkg::*; ();

  localparam int TIMEOUT_CYC   = 1000;
  localparam int STALL_CYC     = 150;
  localparam int STALL_LOW_MIN = 40;
  localparam int BATCH         = 6;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      h_valid_i;
  logic      h_ready_o;
  h_row_t    h_row_i;
  logic      h_last_i;
  wgt_t      wgt_i;
  att_vec_t  att_i;
  logic      feat_valid_o;
  logic      feat_ready_i;
  feat_vec_t feat_o;

  logic [31:0] rng_q;
  int          checks;
  int          value_errs;
  int          other_errs;
  feat_vec_t   exp_q [$];
  h_row_t      sg_rows [BATCH][MAX_NODES];
  int          sg_size [BATCH];
  logic        sg_mark [BATCH];

  gat_layer_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .h_valid_i    (h_valid_i),
    .h_ready_o    (h_ready_o),
    .h_row_i      (h_row_i),
    .h_last_i     (h_last_i),
    .wgt_i        (wgt_i),
    .att_i        (att_i),
    .feat_valid_o (feat_valid_o),
    .feat_ready_i (feat_ready_i),
    .feat_o       (feat_o)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  function automatic longint shift_sat(input longint v, input int sh, input longint lo,
                                       input longint hi);
    longint s;
    s = v >>> sh;
    if (s < lo) begin
      return lo;
    end
    if (s > hi) begin
      return hi;
    end
    return s;
  endfunction

  // Projection, scoring and aggregation of subgraph k
  function automatic feat_vec_t model_feat(input int k);
    longint    wh [MAX_NODES][NUM_FEAT_OUT];
    longint    coef [MAX_NODES];
    longint    sum;
    longint    self_term;
    feat_vec_t res;
    for (int j = 0; j < sg_size[k]; j++) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        sum = 0;
        for (int i = 0; i < NUM_FEAT_IN; i++) begin
          sum += longint'(sg_rows[k][j][i]) * longint'(wgt_i[o][i]);
        end
        wh[j][o] = shift_sat(sum, WH_SHIFT, -(2**(WH_W-1)), 2**(WH_W-1) - 1);
      end
    end
    self_term = 0;
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      self_term += longint'(att_i[o]) * wh[0][o];
    end
    for (int j = 0; j < sg_size[k]; j++) begin
      sum = self_term;
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        sum += longint'(att_i[NUM_FEAT_OUT + o]) * wh[j][o];
      end
      coef[j] = shift_sat(sum, SCORE_SHIFT, 0, 2**COEF_W - 1);
    end
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      sum = 0;
      for (int j = 0; j < sg_size[k]; j++) begin
        sum += coef[j] * wh[j][o];
      end
      res[o] = feat_t'(shift_sat(sum, AGGR_SHIFT, -(2**(FEAT_W-1)), 2**(FEAT_W-1) - 1));
    end
    return res;
  endfunction

  task automatic print_counts();
    $display("Checks: %0d, value errors: %0d, other errors: %0d", checks, value_errs,
             other_errs);
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    other_errs++;
    print_counts();
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic check_feat(input string name, input feat_vec_t got, input feat_vec_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic set_params(input data_t w, input data_t a_self, input data_t a_neigh);
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        wgt_i[o][i] = w;
      end
      att_i[o]                = a_self;
      att_i[NUM_FEAT_OUT + o] = a_neigh;
    end
  endtask

  task automatic randomize_params(input int shift);
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        wgt_i[o][i] = data_t'(next_rand()) >>> shift;
      end
    end
    for (int a = 0; a < 2 * NUM_FEAT_OUT; a++) begin
      att_i[a] = data_t'(next_rand()) >>> (shift + 1);
    end
  endtask

  // Fills subgraph k and queues its expected output
  task automatic prepare_random(input int k, input int n, input logic mark, input int shift);
    sg_size[k] = n;
    sg_mark[k] = mark;
    for (int j = 0; j < MAX_NODES; j++) begin
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        sg_rows[k][j][i] = data_t'(next_rand()) >>> shift;
      end
    end
    exp_q.push_back(model_feat(k));
  endtask

  task automatic fill_const(input int k, input int n, input logic mark, input data_t v);
    sg_size[k] = n;
    sg_mark[k] = mark;
    for (int j = 0; j < MAX_NODES; j++) begin
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        sg_rows[k][j][i] = v;
      end
    end
  endtask

  task automatic send_row(input h_row_t row, input logic last);
    int waited;
    h_valid_i = 1'b1;
    h_row_i   = row;
    h_last_i  = last;
    waited    = 0;
    @(negedge clk);
    while (!h_ready_o) begin
      waited++;
      if (waited > TIMEOUT_CYC) begin
        timeout_fail("h_ready_o");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    h_valid_i = 1'b0;
    h_last_i  = 1'b0;
  endtask

  // A fourth row without mark goes out with h_last_i low
  task automatic send_subgraph(input int k);
    logic last;
    for (int j = 0; j < sg_size[k]; j++) begin
      last = (j == sg_size[k] - 1) && (sg_size[k] < MAX_NODES || sg_mark[k]);
      send_row(sg_rows[k][j], last);
    end
  endtask

  task automatic send_batch(input int count);
    for (int k = 0; k < count; k++) begin
      send_subgraph(k);
    end
  endtask

  task automatic collect_outputs(input int count, input int stall_cycles, input logic rnd);
    int          got;
    int          cyc;
    int          idle;
    int          low_run;
    int          max_low_run;
    logic [31:0] r;
    logic        held_valid;
    feat_vec_t   exp;
    got         = 0;
    cyc         = 0;
    idle        = 0;
    low_run     = 0;
    max_low_run = 0;
    held_valid  = 1'b0;
    while (got < count) begin
      @(posedge clk);
      #1;
      r = next_rand();
      if (cyc < stall_cycles) begin
        feat_ready_i = 1'b0;
      end else if (rnd) begin
        feat_ready_i = r[0];
      end else begin
        feat_ready_i = 1'b1;
      end
      @(negedge clk);
      if (cyc < stall_cycles) begin
        low_run = h_ready_o ? 0 : low_run + 1;
        if (low_run > max_low_run) begin
          max_low_run = low_run;
        end
      end
      // Output refused last cycle must still be valid
      if (held_valid) begin
        check_bit("feat_valid_o", feat_valid_o, 1'b1);
      end
      held_valid = 1'b0;
      if (feat_valid_o && feat_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output transfer arrived with no subgraph pending");
          other_errs++;
        end else begin
          exp = exp_q.pop_front();
          check_feat("feat_o", feat_o, exp);
        end
        got++;
        idle = 0;
      end else begin
        // A stalled output already shows the pending result
        if (feat_valid_o) begin
          held_valid = 1'b1;
          if (exp_q.size() > 0) begin
            check_feat("feat_o held", feat_o, exp_q[0]);
          end
        end
        idle++;
        if (idle > TIMEOUT_CYC + stall_cycles) begin
          timeout_fail("feat_valid_o");
        end
      end
      cyc++;
    end
    @(posedge clk);
    #1;
    feat_ready_i = 1'b0;
    if (stall_cycles > 0) begin
      check_bit("h_ready_o low during stall", max_low_run > STALL_LOW_MIN, 1'b1);
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_bit("feat_valid_o", feat_valid_o, 1'b0);
    check_bit("h_ready_o", h_ready_o, 1'b1);
    @(posedge clk);
    #1;
  endtask

  task automatic test_single_node();
    randomize_params(1);
    prepare_random(0, 1, 1'b1, 1);
    send_subgraph(0);
    collect_outputs(1, 0, 1'b0);
  endtask

  task automatic test_four_nodes();
    randomize_params(1);
    prepare_random(0, MAX_NODES, 1'b0, 1);
    send_subgraph(0);
    collect_outputs(1, 0, 1'b0);
  endtask

  task automatic test_saturation();
    // Wh saturated high while negative scores clamp every coefficient to 0
    set_params(8'sd127, -8'sd128, -8'sd128);
    fill_const(0, 2, 1'b1, 8'sd127);
    exp_q.push_back('0);
    send_subgraph(0);
    collect_outputs(1, 0, 1'b0);
    set_params(8'sd127, 8'sd127, 8'sd127);
    fill_const(0, 2, 1'b1, 8'sd127);
    exp_q.push_back(model_feat(0));
    send_subgraph(0);
    collect_outputs(1, 0, 1'b0);
    // Wh saturated low with large positive scores
    set_params(-8'sd128, -8'sd128, -8'sd128);
    fill_const(0, MAX_NODES, 1'b0, 8'sd127);
    exp_q.push_back(model_feat(0));
    send_subgraph(0);
    collect_outputs(1, 0, 1'b0);
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    randomize_params(1);
    for (int k = 0; k < 5; k++) begin
      r = next_rand();
      prepare_random(k, 1 + int'(r % 4), r[8], 1);
    end
    fork
      send_batch(5);
      collect_outputs(5, STALL_CYC, 1'b0);
    join
  endtask

  task automatic test_random_ready();
    logic [31:0] r;
    randomize_params(2);
    for (int k = 0; k < BATCH; k++) begin
      r = next_rand();
      prepare_random(k, 1 + int'(r % 4), r[8], 0);
    end
    fork
      send_batch(BATCH);
      collect_outputs(BATCH, 0, 1'b1);
    join
  endtask

  initial begin
    rng_q        = 32'd85877;
    checks       = 0;
    value_errs   = 0;
    other_errs   = 0;
    rst_n        = 1'b0;
    h_valid_i    = 1'b0;
    h_row_i      = '0;
    h_last_i     = 1'b0;
    wgt_i        = '0;
    att_i        = '0;
    feat_ready_i = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_single_node();
    test_four_nodes();
    test_saturation();
    test_backpressure();
    test_random_ready();
    print_counts();
    if (value_errs == 0 && other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
gat_pkg.sv
mem_if.sv
shared_mem_arbiter.sv
wh_projection.sv
attention_scorer.sv
neighbor_aggregator.sv
gat_layer_top.sv
tb_gat_layer.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_gat_layer -f src.f
out=$(./obj_dir/Vtb_gat_layer)
echo "$out"
if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
